// ==== filelist.f ====
hw/armCtrlPkg.sv
hw/mainDecoder.sv
hw/aluDecoder.sv
hw/condUnit.sv
hw/memoryMask.sv
hw/controller.sv
sim/ctrlChecker.sv
sim/controllerTb.sv

// ==== Bender.yml ====
package:
  name: arm_ctrl

sources:
  - files:
      - hw/armCtrlPkg.sv
      - hw/mainDecoder.sv
      - hw/aluDecoder.sv
      - hw/condUnit.sv
      - hw/memoryMask.sv
      - hw/controller.sv
  - target: simulation
    files:
      - sim/ctrlChecker.sv
      - sim/controllerTb.sv

// ==== sim/controllerTb.sv ====
`timescale 1ns/1ps

module controllerTb;
  import armCtrlPkg::*;

  localparam int ROWS       = 31;
  localparam int PERIOD_NS  = 4;
  localparam int TIMEOUT_NS = (ROWS * 3 + 20) * PERIOD_NS;

  // Row control {flushE, stallE, stallM, flushW, stallW}
  localparam logic [4:0] RUN   = 5'b00000;
  localparam logic [4:0] FL_E  = 5'b10000;
  localparam logic [4:0] ST_E  = 5'b01000;
  localparam logic [4:0] ST_MW = 5'b00101;
  localparam logic [4:0] FL_W  = 5'b00010;

  localparam instrT NOP = 32'hE1A00000;  // MOV r0, r0

  logic        clk, rstN;
  instrT       instrD;
  flagsT       aluFlagsE, multFlagsE;
  logic [1:0]  addrLowE;
  logic        flushE, stallE, stallM, flushW, stallW, tFlagE;
  logic [1:0]  regSrcD, immSrcD;
  logic        bxInstrD, multSelectD, aluSrcE;
  aluCtrlT     aluControlE;
  aluOpT       aluOperationE;
  logic [2:0]  cvUpdateE;
  logic        invertBE, reverseInputsE, aluCarryE, branchTakenE, multEnableE;
  flagsT       flagsE;
  logic        tFlagNextE, memWriteM, memtoRegM, regWriteM;
  byteMaskT    byteMaskM;
  logic        memtoRegW, regWriteW, pcSrcW, loadLengthW;
  logic [1:0]  byteOffsetW;
  logic        writeHalfwordW, pcWrPendingF;
  int          errors;
  logic [43:0] stim [ROWS];  // {instr, aluFlags, addrLow, control, random}
  int          nRows;
  int          seed;
  logic [31:0] seedDraw;

  controller uut (.*);

  ctrlChecker scoreboard (.*);

  always #(PERIOD_NS / 2) clk = ~clk;

  task automatic addRow(input instrT instr, input flagsT flags, input logic [1:0] addr,
                        input logic [4:0] ctl, input logic rnd);
    stim[nRows] = {instr, flags, addr, ctl, rnd};
    nRows++;
  endtask

  // ====================
  // Stimulus table
  // ====================
  // Flags and address of a row feed the instruction issued one row earlier
  task automatic loadTable();
    addRow(32'hE3A01005, 4'h0, 2'd0, RUN, 1'b0);    // MOV r1, #5
    addRow(32'hE0912003, 4'h0, 2'd0, RUN, 1'b1);    // ADDS r2, r1, r3
    addRow(32'hE1520001, 4'b0100, 2'd0, RUN, 1'b0); // CMP, ADDS gives Z
    addRow(32'h0A000004, 4'b0110, 2'd0, RUN, 1'b0); // BEQ, CMP gives Z C
    addRow(32'h12411001, 4'h0, 2'd0, RUN, 1'b1);    // SUBNE must not write
    addRow(32'hE0643002, 4'h0, 2'd0, RUN, 1'b1);    // RSB
    addRow(32'hE1130004, 4'h0, 2'd0, RUN, 1'b1);    // TST
    addRow(32'hE3C12003, 4'b1000, 2'd0, RUN, 1'b0); // BIC, TST gives N
    addRow(32'hE0A12003, 4'h0, 2'd0, RUN, 1'b1);    // ADC
    addRow(32'hE0D12003, 4'h0, 2'd0, RUN, 1'b1);    // SBCS
    addRow(32'hE0140392, 4'b0011, 2'd0, RUN, 1'b0); // MULS, SBCS gives C V
    addRow(32'h1A000002, 4'h0, 2'd0, RUN, 1'b1);    // BNE on multiplier Z
    addRow(32'hE12FFF1E, 4'h0, 2'd0, RUN, 1'b1);    // BX lr
    addRow(32'hE5821004, 4'h0, 2'd0, RUN, 1'b1);    // STR
    addRow(32'hE5C21001, 4'h0, 2'd0, RUN, 1'b1);    // STRB
    addRow(32'hE1C210B2, 4'h0, 2'd0, RUN, 1'b1);    // STRH
    addRow(32'hE5921000, 4'h0, 2'd2, RUN, 1'b0);    // LDR, STRH upper half
    addRow(32'hE5521001, 4'h0, 2'd0, RUN, 1'b1);    // LDRB with offset down
    addRow(32'hE1D210B2, 4'h0, 2'd3, RUN, 1'b0);    // LDRH, LDRB lane 3
    addRow(32'hE08FF003, 4'h0, 2'd2, RUN, 1'b0);    // ADD pc, pc, r3
    addRow(32'hE1812003, 4'h0, 2'd0, FL_E, 1'b1);   // ORR squashed to a bubble
    addRow(32'hE0212003, 4'h0, 2'd0, RUN, 1'b1);    // EOR
    addRow(32'hE0112003, 4'h0, 2'd0, ST_E, 1'b1);   // EOR held one more cycle
    addRow(32'hE0112003, 4'h0, 2'd0, RUN, 1'b1);    // ANDS reissued
    addRow(32'h012FFF13, 4'b0100, 2'd0, RUN, 1'b0); // BXEQ, ANDS gives Z
    addRow(32'hE1330004, 4'h0, 2'd0, RUN, 1'b1);    // TEQ
    addRow(32'hE1730004, 4'h0, 2'd0, ST_MW, 1'b1);  // CMN, M and W held
    addRow(32'hE3A00000, 4'h0, 2'd0, FL_W, 1'b1);   // MOV r0, #0, W cleared
    addRow(NOP, 4'h0, 2'd0, RUN, 1'b1);
    addRow(NOP, 4'h0, 2'd0, RUN, 1'b1);
    addRow(NOP, 4'h0, 2'd0, RUN, 1'b1);
  endtask

  task automatic applyRow(input logic [43:0] r);
    logic [31:0] rndWord;
    rndWord    = $urandom;
    instrD     = r[43:12];
    aluFlagsE  = r[0] ? rndWord[3:0] : r[11:8];
    addrLowE   = r[0] ? rndWord[5:4] : r[7:6];
    multFlagsE = rndWord[11:8];
    tFlagE     = rndWord[12];
    {flushE, stallE, stallM, flushW, stallW} = r[5:1];
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: run still busy after %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin : mainFlow
    seed     = 19;
    seedDraw = $urandom(seed);
    clk        = 1'b0;
    rstN       = 1'b0;
    instrD     = NOP;
    aluFlagsE  = '0;
    multFlagsE = '0;
    addrLowE   = '0;
    {flushE, stallE, stallM, flushW, stallW, tFlagE} = '0;
    nRows = 0;
    loadTable();
    repeat (2) @(posedge clk);
    #1 rstN = 1'b1;
    for (int i = 0; i < nRows; i++) begin
      @(posedge clk);
      #1;
      applyRow(stim[i]);
    end
    @(posedge clk);
    @(negedge clk);  // Last row gets its check
    $display("Summary: %0d rows applied, %0d errors", nRows, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sim/ctrlChecker.sv ====
`timescale 1ns/1ps

module ctrlChecker (
  input  logic                 clk, rstN,
  input  armCtrlPkg::instrT    instrD,
  input  armCtrlPkg::flagsT    aluFlagsE, multFlagsE,
  input  logic [1:0]           addrLowE,
  input  logic                 flushE, stallE, stallM, flushW, stallW, tFlagE,
  input  logic [1:0]           regSrcD, immSrcD,
  input  logic                 bxInstrD, multSelectD, aluSrcE,
  input  armCtrlPkg::aluCtrlT  aluControlE,
  input  armCtrlPkg::aluOpT    aluOperationE,
  input  logic [2:0]           cvUpdateE,
  input  logic                 invertBE, reverseInputsE, aluCarryE, branchTakenE, multEnableE,
  input  armCtrlPkg::flagsT    flagsE,
  input  logic                 tFlagNextE, memWriteM, memtoRegM, regWriteM,
  input  armCtrlPkg::byteMaskT byteMaskM,
  input  logic                 memtoRegW, regWriteW, pcSrcW, loadLengthW,
  input  logic [1:0]           byteOffsetW,
  input  logic                 writeHalfwordW, pcWrPendingF,
  output int                   errors
);
  import armCtrlPkg::*;

  typedef struct packed {
    logic       valid;
    logic [3:0] cond;
    logic       dp, mul, half, ls, br, bx, aluOn;
    logic [3:0] opc;
    logic       sBit, iBit, bBit;
    logic       regWr, memWr, load, pcWr;
    aluCtrlT    ctl;
  } decodedT;

  typedef struct packed {
    logic       regWr, memWr, memtoReg, pcSrc, loadLength, writeHalf;
    logic [1:0] byteOffset;
    byteMaskT   byteMask;
  } memStageT;

  decodedT  stE;  // Model of the execute slot
  memStageT stM;
  memStageT stW;
  flagsT    flagsQ;
  logic     tFlagQ;

  initial errors = 0;

  // ====================
  // Reference rules
  // ====================
  function automatic decodedT decode(input instrT w);
    decodedT    d;
    logic [3:0] rd;
    d       = '0;
    d.valid = 1'b1;
    d.cond  = w[31:28];
    d.mul   = (w[27:22] == 6'b000000) && (w[7:4] == 4'b1001);  // MUL, MLA
    d.half  = (w[27:25] == 3'b000) && (w[7:4] == 4'b1011);     // LDRH, STRH
    d.bx    = (w[27:4] == 24'h12FFF1);
    d.dp    = (w[27:26] == 2'b00) && !d.mul && !d.half && !d.bx;
    d.ls    = (w[27:26] == 2'b01);
    d.br    = (w[27:25] == 3'b101);
    d.aluOn = d.dp || d.ls || d.half;
    d.opc   = w[24:21];
    d.sBit  = w[20];
    d.iBit  = w[25];
    d.bBit  = d.ls && w[22];
    d.load  = (d.ls || d.half) && w[20];
    d.memWr = (d.ls || d.half) && !w[20];
    d.regWr = d.dp || d.mul || d.load;
    rd      = d.mul ? w[19:16] : w[15:12];
    d.pcWr  = d.br || d.bx || (d.regWr && (rd == 4'd15));
    d.ctl   = d.dp ? w[24:21] : (w[23] ? 4'b0100 : 4'b0010);  // U picks add or sub
    return d;
  endfunction

  // {regSrc, immSrc} by instruction class
  function automatic logic [3:0] srcExpect(input decodedT d, input instrT w);
    if (d.ls || d.half) return {~w[20], 1'b0, (d.half ? 2'b11 : 2'b01)};
    if (d.br || d.bx) return 4'b0110;
    return 4'b0000;
  endfunction

  // Odd codes invert the even ones, 111x is AL or never
  function automatic logic passes(input condT c, input flagsT f);
    logic base;
    logic n, z, cf, v;
    {n, z, cf, v} = f;
    case (c[3:1])
      3'd0:    base = z;
      3'd1:    base = cf;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = cf & ~z;
      3'd5:    base = (n == v);
      3'd6:    base = ~z & (n == v);
      default: base = 1'b1;
    endcase
    return (c[3:1] == 3'd7) ? (c == 4'hE) : (base ^ c[0]);
  endfunction

  // {arith, op, invertB, reverse, carry}
  function automatic logic [6:0] aluExpect(input aluCtrlT ctl, input logic cIn);
    logic [6:0] r;
    case (ctl)
      4'h0, 4'h8: r = {1'b0, OP_AND, 3'b000};
      4'h1, 4'h9: r = {1'b0, OP_XOR, 3'b000};
      4'h2, 4'hA: r = {1'b1, OP_ADD, 3'b101};
      4'h3:       r = {1'b1, OP_ADD, 3'b111};
      4'h4, 4'hB: r = {1'b1, OP_ADD, 3'b000};
      4'h5:       r = {1'b1, OP_ADD, 2'b00, cIn};
      4'h6:       r = {1'b1, OP_ADD, 2'b10, cIn};
      4'h7:       r = {1'b1, OP_ADD, 2'b11, cIn};
      4'hC:       r = {1'b0, OP_OR,  3'b000};
      4'hD:       r = {1'b0, OP_MOV, 3'b000};
      4'hE:       r = {1'b0, OP_BIC, 3'b000};
      default:    r = {1'b0, OP_MVN, 3'b000};
    endcase
    return r;
  endfunction

  function automatic byteMaskT laneMask(input logic isByte, input logic isHalf,
                                        input logic [1:0] addr);
    if (isByte) return byteMaskT'(4'b0001 << addr);
    if (isHalf) return addr[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  task automatic compareVal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %0h, got %0h at %0t", name, exp, act, $time);
    end
  endtask

  // ====================
  // Pipeline model
  // ====================
  always @(posedge clk) begin : advance
    memStageT   nextM;
    flagsT      newF;
    flagsT      nextF;
    logic [6:0] aluE;
    logic       pass;
    logic       noWr;
    if (!rstN) begin
      stE    <= '0;
      stM    <= '0;
      stW    <= '0;
      flagsQ <= '0;
      tFlagQ <= 1'b0;
    end else begin
      pass = passes(stE.cond, flagsQ);
      aluE = aluExpect(stE.ctl, flagsQ[FLAG_C]);
      noWr = stE.dp && (stE.opc[3:2] == 2'b10);  // TST TEQ CMP CMN
      nextM.regWr      = stE.regWr && pass && !noWr;
      nextM.memWr      = stE.memWr && pass;
      nextM.memtoReg   = stE.load;
      nextM.pcSrc      = stE.pcWr && pass && !noWr;
      nextM.loadLength = stE.bBit;
      nextM.writeHalf  = stE.half;
      nextM.byteOffset = addrLowE;
      nextM.byteMask   = laneMask(stE.bBit, stE.half, addrLowE);
      newF  = stE.mul ? multFlagsE : aluFlagsE;
      nextF = flagsQ;
      if (!stallE && pass && stE.sBit && (stE.dp || stE.mul)) begin
        nextF[FLAG_N] = newF[FLAG_N];
        nextF[FLAG_Z] = newF[FLAG_Z];
        if (stE.dp && aluE[6]) begin  // Logic ops leave C and V alone
          nextF[FLAG_C] = newF[FLAG_C];
          nextF[FLAG_V] = newF[FLAG_V];
        end
      end
      flagsQ <= nextF;
      if (!stallE && pass && stE.bx) tFlagQ <= tFlagE;
      if (!stallM) stM <= nextM;
      if (flushW) stW <= '0;
      else if (!stallW) stW <= stM;
      if (flushE) stE <= '0;
      else if (!stallE) stE <= decode(instrD);
    end
  end

  // Outputs are settled half a cycle after the edge
  always @(negedge clk) begin : compare
    decodedT    dD;
    logic [6:0] alu;
    logic [3:0] src;
    logic       pass;
    if (rstN) begin
      dD   = decode(instrD);
      src  = srcExpect(dD, instrD);
      pass = passes(stE.cond, flagsQ);
      alu  = stE.aluOn ? aluExpect(stE.ctl, flagsQ[FLAG_C]) : {1'b0, OP_ADD, 3'b000};
      compareVal("regSrcD", src[3:2], regSrcD);
      compareVal("immSrcD", src[1:0], immSrcD);
      compareVal("bxInstrD", dD.bx, bxInstrD);
      compareVal("multSelectD", dD.mul, multSelectD);
      compareVal("pcWrPendingF", dD.pcWr | stE.pcWr | stM.pcSrc, pcWrPendingF);
      compareVal("flagsE", flagsQ, flagsE);
      compareVal("branchTakenE", (stE.br | stE.bx) & pass, branchTakenE);
      compareVal("multEnableE", stE.mul & pass, multEnableE);
      compareVal("tFlagNextE", (stE.bx && pass) ? tFlagE : tFlagQ, tFlagNextE);
      compareVal("aluOperationE", alu[5:3], aluOperationE);
      compareVal("invertBE", alu[2], invertBE);
      compareVal("reverseInputsE", alu[1], reverseInputsE);
      compareVal("aluCarryE", alu[0], aluCarryE);
      compareVal("cvUpdateE nonzero", alu[6], |cvUpdateE);
      if (stE.aluOn) compareVal("aluControlE", stE.ctl, aluControlE);
      if (stE.dp) compareVal("aluSrcE", stE.iBit, aluSrcE);
      compareVal("regWriteM", stM.regWr, regWriteM);
      compareVal("memWriteM", stM.memWr, memWriteM);
      compareVal("memtoRegM", stM.memtoReg, memtoRegM);
      if (stM.memWr) compareVal("byteMaskM", stM.byteMask, byteMaskM);
      compareVal("regWriteW", stW.regWr, regWriteW);
      compareVal("memtoRegW", stW.memtoReg, memtoRegW);
      compareVal("pcSrcW", stW.pcSrc, pcSrcW);
      compareVal("loadLengthW", stW.loadLength, loadLengthW);
      compareVal("byteOffsetW", stW.byteOffset, byteOffsetW);
      compareVal("writeHalfwordW", stW.writeHalf, writeHalfwordW);
    end
  end

endmodule

// ==== hw/controller.sv ====
`timescale 1ns/1ps

module controller (
  input  logic                clk,
  input  logic                rstN,
  input  armCtrlPkg::instrT   instrD,
  input  armCtrlPkg::flagsT   aluFlagsE,
  input  armCtrlPkg::flagsT   multFlagsE,
  input  logic [1:0]          addrLowE,
  input  logic                flushE,
  input  logic                stallE,
  input  logic                stallM,
  input  logic                flushW,
  input  logic                stallW,
  input  logic                tFlagE,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output logic                bxInstrD,
  output logic                multSelectD,
  output logic                aluSrcE,
  output armCtrlPkg::aluCtrlT aluControlE,
  output armCtrlPkg::aluOpT   aluOperationE,
  output logic [2:0]          cvUpdateE,
  output logic                invertBE,
  output logic                reverseInputsE,
  output logic                aluCarryE,
  output logic                branchTakenE,
  output logic                multEnableE,
  output armCtrlPkg::flagsT   flagsE,
  output logic                tFlagNextE,
  output logic                memWriteM,
  output logic                memtoRegM,
  output logic                regWriteM,
  output armCtrlPkg::byteMaskT byteMaskM,
  output logic                memtoRegW,
  output logic                regWriteW,
  output logic                pcSrcW,
  output logic                loadLengthW,
  output logic [1:0]          byteOffsetW,
  output logic                writeHalfwordW,
  output logic                pcWrPendingF
);
  import armCtrlPkg::*;

  logic       aluSrcD, memtoRegD, regWriteD, memWriteD, branchD;
  logic       aluOpD, lsAluOpD, halfwordD, pcSrcD;
  aluCtrlT    aluControlD;
  logic [1:0] flagWriteD;
  instrT      instrE;
  logic [1:0] flagWriteE;
  logic       memtoRegE, regWriteE, memWriteE, branchE, pcSrcE;
  logic       aluOpE, bxInstrE, multSelectE, halfwordE;
  logic       condExE, doNotWriteRegE;
  logic       regWriteGatedE, memWriteGatedE, pcSrcGatedE;
  logic       byteAccessE, halfAccessE;
  byteMaskT   byteMaskE;
  logic       pcSrcM, loadLengthM, writeHalfwordM;
  logic [1:0] byteOffsetM;

  // ====================
  // Decode
  // ====================
  mainDecoder mainDec (
    .instrD(instrD), .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcD(aluSrcD),
    .memtoRegD(memtoRegD), .regWriteD(regWriteD), .memWriteD(memWriteD),
    .branchD(branchD), .aluOpD(aluOpD), .multSelectD(multSelectD), .lsAluOpD(lsAluOpD),
    .bxInstrD(bxInstrD), .halfwordD(halfwordD), .aluControlD(aluControlD),
    .flagWriteD(flagWriteD), .pcSrcD(pcSrcD), .multControlD()
  );

  // ====================
  // Execute
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin  // Flush loads a bubble
      {instrE, aluSrcE, aluControlE, flagWriteE} <= '0;
      {memtoRegE, regWriteE, memWriteE, branchE, pcSrcE} <= '0;
      {aluOpE, bxInstrE, multSelectE, halfwordE} <= '0;
    end else if (!stallE) begin
      instrE      <= instrD;
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      flagWriteE  <= flagWriteD;
      memtoRegE   <= memtoRegD;
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      branchE     <= branchD;
      pcSrcE      <= pcSrcD;
      aluOpE      <= aluOpD | lsAluOpD;  // Loads/stores need add or sub too
      bxInstrE    <= bxInstrD;
      multSelectE <= multSelectD;
      halfwordE   <= halfwordD;
    end
  end

  aluDecoder aluDec (
    .aluOpE(aluOpE), .aluControlE(aluControlE), .carryIn(flagsE[FLAG_C]),
    .aluOperationE(aluOperationE), .cvUpdateE(cvUpdateE), .invertBE(invertBE),
    .reverseInputsE(reverseInputsE), .aluCarryE(aluCarryE), .doNotWriteRegE(doNotWriteRegE)
  );

  condUnit cond (
    .clk(clk), .rstN(rstN), .enable(~stallE), .condE(instrE[COND_HI:COND_LO]),
    .aluFlagsE(aluFlagsE), .multFlagsE(multFlagsE), .flagWriteE(flagWriteE),
    .multSelectE(multSelectE), .arithE(|cvUpdateE), .bxE(bxInstrE), .tFlagE(tFlagE),
    .condExE(condExE), .flagsE(flagsE), .tFlagNextE(tFlagNextE)
  );

  // LDRSB counts as a byte access
  assign byteAccessE = ((instrE[27:26] == 2'b01) & instrE[B_BIT]) | (halfwordE & ~instrE[5]);
  assign halfAccessE = halfwordE & instrE[5];

  memoryMask memMask (
    .byteE(byteAccessE), .halfwordE(halfAccessE), .addrLow(addrLowE), .byteMask(byteMaskE)
  );

  // Condition gating
  assign regWriteGatedE = regWriteE & condExE & ~doNotWriteRegE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE & ~doNotWriteRegE;
  assign branchTakenE   = branchE & condExE;
  assign multEnableE    = multSelectE & condExE;

  // ====================
  // Memory
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM} <= '0;
      {byteMaskM, loadLengthM, byteOffsetM, writeHalfwordM} <= '0;
    end else if (!stallM) begin
      memWriteM      <= memWriteGatedE;
      memtoRegM      <= memtoRegE;
      regWriteM      <= regWriteGatedE;
      pcSrcM         <= pcSrcGatedE;
      byteMaskM      <= byteMaskE;
      loadLengthM    <= byteAccessE;
      byteOffsetM    <= addrLowE;
      writeHalfwordM <= halfAccessE;
    end
  end

  // ====================
  // Writeback
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      {memtoRegW, regWriteW, pcSrcW} <= '0;
      {loadLengthW, byteOffsetW, writeHalfwordW} <= '0;
    end else if (!stallW) begin
      memtoRegW      <= memtoRegM;
      regWriteW      <= regWriteM;
      pcSrcW         <= pcSrcM;
      loadLengthW    <= loadLengthM;
      byteOffsetW    <= byteOffsetM;
      writeHalfwordW <= writeHalfwordM;
    end
  end

  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;  // Hazard unit holds fetch on this

  // Bubble from a flushed E slot lands in M two edges later
  flushEBubble: assert property (@(posedge clk) disable iff (!rstN)
    flushE ##1 !stallM |=> !regWriteM);
  flushWBubble: assert property (@(posedge clk) disable iff (!rstN)
    flushW |=> !regWriteW);

endmodule

// ==== hw/memoryMask.sv ====
`timescale 1ns/1ps

module memoryMask (
  input  logic                 byteE,
  input  logic                 halfwordE,
  input  logic [1:0]           addrLow,
  output armCtrlPkg::byteMaskT byteMask
);

  // Lane select by access size
  always_comb begin
    if (byteE) begin
      case (addrLow)
        2'd0:    byteMask = 4'b0001;
        2'd1:    byteMask = 4'b0010;
        2'd2:    byteMask = 4'b0100;
        default: byteMask = 4'b1000;
      endcase
    end else if (halfwordE) begin
      // Upper half when address bit 1 set
      byteMask = addrLow[1] ? 4'b1100 : 4'b0011;
    end else begin
      byteMask = 4'b1111;  // Word
    end
  end

endmodule

// ==== hw/condUnit.sv ====
`timescale 1ns/1ps

module condUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              enable,
  input  armCtrlPkg::condT  condE,
  input  armCtrlPkg::flagsT aluFlagsE,
  input  armCtrlPkg::flagsT multFlagsE,
  input  logic [1:0]        flagWriteE,
  input  logic              multSelectE,
  input  logic              arithE,
  input  logic              bxE,
  input  logic              tFlagE,
  output logic              condExE,
  output armCtrlPkg::flagsT flagsE,
  output logic              tFlagNextE
);
  import armCtrlPkg::*;

  flagsT newFlags;
  flagsT flagsNext;
  logic  tFlagQ;
  logic  nFlag;
  logic  zFlag;
  logic  cFlag;
  logic  vFlag;
  logic  updNz;
  logic  updCv;

  assign nFlag = flagsE[FLAG_N];
  assign zFlag = flagsE[FLAG_Z];
  assign cFlag = flagsE[FLAG_C];
  assign vFlag = flagsE[FLAG_V];

  // ====================
  // Condition check
  // ====================
  always_comb begin
    case (condE)
      4'h0:    condExE = zFlag;                       // EQ
      4'h1:    condExE = ~zFlag;                      // NE
      4'h2:    condExE = cFlag;                       // CS
      4'h3:    condExE = ~cFlag;                      // CC
      4'h4:    condExE = nFlag;                       // MI
      4'h5:    condExE = ~nFlag;                      // PL
      4'h6:    condExE = vFlag;                       // VS
      4'h7:    condExE = ~vFlag;                      // VC
      4'h8:    condExE = cFlag & ~zFlag;              // HI
      4'h9:    condExE = ~cFlag | zFlag;              // LS
      4'hA:    condExE = (nFlag == vFlag);            // GE
      4'hB:    condExE = (nFlag != vFlag);            // LT
      4'hC:    condExE = ~zFlag & (nFlag == vFlag);   // GT
      4'hD:    condExE = zFlag | (nFlag != vFlag);    // LE
      4'hE:    condExE = 1'b1;                        // AL
      default: condExE = 1'b0;                        // NV never runs
    endcase
  end

  // Next flags
  assign newFlags = multSelectE ? multFlagsE : aluFlagsE;
  assign updNz    = condExE & flagWriteE[1];
  assign updCv    = condExE & flagWriteE[0] & arithE;  // Logic ops keep C and V

  always_comb begin
    flagsNext = flagsE;
    if (updNz) begin
      flagsNext[FLAG_N] = newFlags[FLAG_N];
      flagsNext[FLAG_Z] = newFlags[FLAG_Z];
    end
    if (updCv) begin
      flagsNext[FLAG_C] = newFlags[FLAG_C];
      flagsNext[FLAG_V] = newFlags[FLAG_V];
    end
  end

  assign tFlagNextE = (bxE & condExE) ? tFlagE : tFlagQ;

  // Flags and Thumb bit
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsE <= '0;
      tFlagQ <= 1'b0;
    end else if (enable) begin
      flagsE <= flagsNext;
      tFlagQ <= tFlagNextE;
    end
  end

endmodule

// ==== hw/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder (
  input  logic                aluOpE,
  input  armCtrlPkg::aluCtrlT aluControlE,
  input  logic                carryIn,
  output armCtrlPkg::aluOpT   aluOperationE,
  output logic [2:0]          cvUpdateE,
  output logic                invertBE,
  output logic                reverseInputsE,
  output logic                aluCarryE,
  output logic                doNotWriteRegE
);
  import armCtrlPkg::*;

  // C from adder, V from adder, C as not-borrow
  localparam logic [2:0] CV_ADD = 3'b110;
  localparam logic [2:0] CV_SUB = 3'b111;

  always_comb begin
    aluOperationE  = OP_ADD;
    cvUpdateE      = 3'b000;
    invertBE       = 1'b0;
    reverseInputsE = 1'b0;
    aluCarryE      = 1'b0;
    if (aluOpE) begin
      case (aluControlE)
        4'b0000, 4'b1000: aluOperationE = OP_AND;  // AND, TST
        4'b0001, 4'b1001: aluOperationE = OP_XOR;  // EOR, TEQ
        4'b0010, 4'b1010, 4'b0011: begin           // SUB, CMP, RSB
          cvUpdateE      = CV_SUB;
          invertBE       = 1'b1;
          aluCarryE      = 1'b1;
          reverseInputsE = (aluControlE == 4'b0011);
        end
        4'b0100, 4'b1011: cvUpdateE = CV_ADD;      // ADD, CMN
        4'b0101: begin                             // ADC
          cvUpdateE = CV_ADD;
          aluCarryE = carryIn;
        end
        4'b0110, 4'b0111: begin                    // SBC, RSC
          cvUpdateE      = CV_SUB;
          invertBE       = 1'b1;
          aluCarryE      = carryIn;
          reverseInputsE = aluControlE[0];
        end
        4'b1100: aluOperationE = OP_OR;
        4'b1101: aluOperationE = OP_MOV;
        4'b1110: aluOperationE = OP_BIC;
        default: aluOperationE = OP_MVN;
      endcase
    end
  end

  // Compare and test group only touches flags
  assign doNotWriteRegE = aluOpE && (aluControlE[3:2] == 2'b10);

endmodule

// ==== hw/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
  input  armCtrlPkg::instrT   instrD,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output logic                aluSrcD,
  output logic                memtoRegD,
  output logic                regWriteD,
  output logic                memWriteD,
  output logic                branchD,
  output logic                aluOpD,
  output logic                multSelectD,
  output logic                lsAluOpD,
  output logic                bxInstrD,
  output logic                halfwordD,
  output armCtrlPkg::aluCtrlT aluControlD,
  output logic [1:0]          flagWriteD,
  output logic                pcSrcD,
  output logic [2:0]          multControlD
);
  import armCtrlPkg::*;

  logic       isDpD;
  logic       isMulD;
  logic       isHalfD;
  logic       isLsD;
  logic       isBranchD;
  logic       isBxD;
  logic [3:0] rdD;

  // ====================
  // Instruction class
  // ====================
  assign isMulD    = (instrD[27:24] == 4'b0000) && (instrD[7:4] == 4'b1001);
  assign isHalfD   = (instrD[27:25] == 3'b000) && instrD[7] && instrD[4] &&
                     (instrD[6:5] != 2'b00);
  assign isBxD     = (instrD[27:4] == 24'h12FFF1);
  assign isDpD     = (instrD[27:26] == 2'b00) && !isMulD && !isHalfD && !isBxD;
  assign isLsD     = (instrD[27:26] == 2'b01);
  assign isBranchD = (instrD[27:25] == 3'b101);  // LDM/STM and coprocessor fall out

  // Control word, all off for unknown classes
  always_comb begin
    regSrcD     = 2'b00;
    immSrcD     = 2'b00;
    aluSrcD     = 1'b0;
    memtoRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    aluOpD      = 1'b0;
    multSelectD = 1'b0;
    lsAluOpD    = 1'b0;
    if (isDpD) begin
      aluSrcD   = instrD[I_BIT];
      regWriteD = 1'b1;
      aluOpD    = 1'b1;
    end else if (isMulD) begin
      regWriteD   = 1'b1;
      multSelectD = 1'b1;
    end else if (isLsD || isHalfD) begin
      regSrcD   = {~instrD[L_BIT], 1'b0};  // Stores read Rd as data
      immSrcD   = isHalfD ? 2'b11 : 2'b01;
      // Word/byte immediate offset has I clear, halfword uses bit 22
      aluSrcD   = isHalfD ? instrD[22] : ~instrD[I_BIT];
      memtoRegD = instrD[L_BIT];
      regWriteD = instrD[L_BIT];
      memWriteD = ~instrD[L_BIT];
      lsAluOpD  = 1'b1;
    end else if (isBranchD || isBxD) begin
      regSrcD = 2'b01;
      immSrcD = 2'b10;
      aluSrcD = isBranchD;  // BX takes the target from Rm
      branchD = 1'b1;
    end
  end

  // ALU control select
  always_comb begin
    aluControlD = 4'b0100;                        // Add for branches and multiply
    flagWriteD  = {multSelectD & instrD[S_BIT], 1'b0};  // MULS sets NZ only
    if (aluOpD) begin
      aluControlD = instrD[OPC_HI:OPC_LO];
      flagWriteD  = {2{instrD[S_BIT]}};
    end else if (lsAluOpD) begin
      aluControlD = instrD[U_BIT] ? 4'b0100 : 4'b0010;
    end
  end

  assign rdD          = isMulD ? instrD[19:16] : instrD[15:12];  // MUL keeps Rd up high
  assign pcSrcD       = branchD | (regWriteD & (rdD == PC_REG));
  assign multControlD = instrD[23:21];
  assign bxInstrD     = isBxD;
  assign halfwordD    = isHalfD;

endmodule

// ==== hw/armCtrlPkg.sv ====
package armCtrlPkg;

  // ====================
  // Vector types
  // ====================
  typedef logic [31:0] instrT;
  typedef logic [3:0]  flagsT;     // N Z C V from the top
  typedef logic [3:0]  condT;
  typedef logic [3:0]  aluCtrlT;   // Data-processing opcode
  typedef logic [2:0]  aluOpT;
  typedef logic [3:0]  byteMaskT;  // One bit per byte lane

  // ====================
  // ALU operations
  // ====================
  localparam aluOpT OP_AND = 3'd0;
  localparam aluOpT OP_OR  = 3'd1;
  localparam aluOpT OP_XOR = 3'd2;
  localparam aluOpT OP_ADD = 3'd3;  // Also sub, rsb, adc, sbc via modifiers
  localparam aluOpT OP_MOV = 3'd4;
  localparam aluOpT OP_BIC = 3'd5;
  localparam aluOpT OP_MVN = 3'd6;

  // ====================
  // Instruction fields
  // ====================
  localparam int COND_HI = 31;
  localparam int COND_LO = 28;
  localparam int OPC_HI  = 24;
  localparam int OPC_LO  = 21;
  localparam int I_BIT   = 25;
  localparam int U_BIT   = 23;  // Add offset when set
  localparam int B_BIT   = 22;  // Byte access on LDR/STR
  localparam int S_BIT   = 20;
  localparam int L_BIT   = 20;  // Shares the S position

  localparam logic [3:0] PC_REG = 4'd15;

  // Bit positions inside flagsT
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

endpackage
